// File: src.f
source/fp16_pkg.sv
source/fma_op_pkg.sv
source/fma16_classify.sv
source/fma16_product_stage.sv
source/fma16_fifo.sv
source/fma16_sum_round.sv
source/fma16_unit.sv
dv/fma16_unit_tb.sv

// File: Makefile
TOP := fma16_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: dv/fma16_unit_tb.sv
module fma16_unit_tb;

    localparam int TIMEOUT = 200;   // cycles allowed for any single wait

    // opcode bits {mul, add, negp, negz}
    localparam logic [3:0] OP_FMA = 4'b1100;
    localparam logic [3:0] OP_MUL = 4'b1000;   // z forced to -0
    localparam logic [3:0] OP_ADD = 4'b0100;   // y forced to 1.0
    localparam logic [3:0] OP_NP  = 4'b1110;
    localparam logic [3:0] OP_NZ  = 4'b1101;
    localparam logic [3:0] OP_NPZ = 4'b1111;

    // round modes, reference encoding
    localparam logic [1:0] RZ  = 2'd0;
    localparam logic [1:0] RNE = 2'd1;
    localparam logic [1:0] RDN = 2'd2;
    localparam logic [1:0] RUP = 2'd3;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] z;
    logic        mul;
    logic        add;
    logic        negp;
    logic        negz;
    logic [1:0]  round_mode;
    logic        out_valid;
    logic        out_ready;
    logic [15:0] result;
    logic [3:0]  flags;         // nv, of, uf, nx

    // vector table, one entry per index across all queues
    logic [15:0] vx_q[$];
    logic [15:0] vy_q[$];
    logic [15:0] vz_q[$];
    logic [3:0]  vop_q[$];
    logic [1:0]  vrm_q[$];
    logic [15:0] eres_q[$];       // expected result
    logic [3:0]  eflg_q[$];       // expected flags
    int          n_checked;

    fma16_unit DUT (
        .clk, .rst_n, .in_valid, .in_ready, .x, .y, .z,
        .mul, .add, .negp, .negz, .round_mode,
        .out_valid, .out_ready, .result, .flags
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic add_entry(input logic [15:0] ax, input logic [15:0] ay,
                             input logic [15:0] az, input logic [3:0] op,
                             input logic [1:0] rm, input logic [15:0] res,
                             input logic [3:0] flg);
        vx_q.push_back(ax);
        vy_q.push_back(ay);
        vz_q.push_back(az);
        vop_q.push_back(op);
        vrm_q.push_back(rm);
        eres_q.push_back(res);
        eflg_q.push_back(flg);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [15:0] got,
                                   input logic [15:0] want, input int idx);
        $display("ERROR: %s = 0x%h, expected 0x%h (entry %0d)", sig, got, want, idx);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    // called at a falling edge, returns at the falling edge after the accept
    task automatic send_entry(input int i);
        int  waited;
        bit  taken;
        waited = 0;
        taken  = 1'b0;
        x          = vx_q[i];
        y          = vy_q[i];
        z          = vz_q[i];
        {mul, add, negp, negz} = vop_q[i];
        round_mode = vrm_q[i];
        in_valid   = 1'b1;
        while (!taken) begin
            #1;
            taken = in_ready;   // settled, accept happens on the next rising edge
            @(negedge clk);
            waited++;
            if (!taken && waited > TIMEOUT) abort_run("input was never accepted");
        end
        in_valid = 1'b0;
    endtask

    task automatic feed_inputs();
        int gap;
        for (int i = 0; i < vx_q.size(); i++) begin
            gap = $urandom_range(2, 0);   // idle cycles before this entry
            repeat (gap) @(negedge clk);
            send_entry(i);
        end
    endtask

    // random out_ready, checks each result in table order
    task automatic collect_outputs();
        int idle;
        idle = 0;
        while (n_checked < vx_q.size()) begin
            @(negedge clk);
            out_ready = ($urandom % 2) == 0;
            #1;
            if (out_valid && out_ready) begin
                assert (result === eres_q[n_checked])
                    else report_mismatch("result", result, eres_q[n_checked], n_checked);
                assert (flags === eflg_q[n_checked])
                    else report_mismatch("flags", 16'(flags), 16'(eflg_q[n_checked]),
                                         n_checked);
                n_checked++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) abort_run("expected result did not come out in time");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        void'($urandom(32'h43c7_a2d1));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        x          = '0;
        y          = '0;
        z          = '0;
        mul        = 1'b0;
        add        = 1'b0;
        negp       = 1'b0;
        negz       = 1'b0;
        round_mode = RNE;
        out_ready  = 1'b0;
        n_checked  = 0;

        // flags legend: 1 nx, 3 uf+nx, 5 of+nx, 8 nv
        add_entry(16'h3e00, 16'h4000, 16'h3400, OP_FMA, RNE, 16'h4280, 4'h0); // 1.5*2+0.25
        add_entry(16'h3c00, 16'h3c00, 16'h1200, OP_FMA, RZ,  16'h3c00, 4'h1); // 1 + 0.75 ulp
        add_entry(16'h3c00, 16'h3c00, 16'h1200, OP_FMA, RNE, 16'h3c01, 4'h1);
        add_entry(16'h3c00, 16'h3c00, 16'h1200, OP_FMA, RDN, 16'h3c00, 4'h1);
        add_entry(16'h3c00, 16'h3c00, 16'h1200, OP_FMA, RUP, 16'h3c01, 4'h1);
        add_entry(16'hbc00, 16'h3c00, 16'h9200, OP_FMA, RZ,  16'hbc00, 4'h1); // negated
        add_entry(16'hbc00, 16'h3c00, 16'h9200, OP_FMA, RNE, 16'hbc01, 4'h1);
        add_entry(16'hbc00, 16'h3c00, 16'h9200, OP_FMA, RDN, 16'hbc01, 4'h1);
        add_entry(16'hbc00, 16'h3c00, 16'h9200, OP_FMA, RUP, 16'hbc00, 4'h1);
        add_entry(16'h3c00, 16'h3c00, 16'h1000, OP_FMA, RNE, 16'h3c00, 4'h1); // tie, even
        add_entry(16'h3c01, 16'h3c00, 16'h1000, OP_FMA, RNE, 16'h3c02, 4'h1); // tie, odd up
        add_entry(16'h7e00, 16'h3c00, 16'h0000, OP_FMA, RNE, 16'h7e00, 4'h0); // qnan in
        add_entry(16'h7c01, 16'h3c00, 16'h0000, OP_FMA, RNE, 16'h7e00, 4'h8); // snan in
        add_entry(16'h0000, 16'h7c00, 16'h3c00, OP_FMA, RNE, 16'h7e00, 4'h8); // 0 * inf
        add_entry(16'h7c00, 16'h3c00, 16'hfc00, OP_FMA, RNE, 16'h7e00, 4'h8); // inf - inf
        add_entry(16'h7c00, 16'h4000, 16'h3c00, OP_FMA, RNE, 16'h7c00, 4'h0);
        add_entry(16'h3c00, 16'h3c00, 16'hfc00, OP_FMA, RNE, 16'hfc00, 4'h0); // -inf addend
        add_entry(16'h4200, 16'h4400, 16'h3c00, OP_MUL, RNE, 16'h4a00, 4'h0); // 3*4, z unused
        add_entry(16'h8000, 16'h3c00, 16'h3c00, OP_MUL, RNE, 16'h8000, 4'h0); // -0 kept
        add_entry(16'h0000, 16'h3c00, 16'h3c00, OP_MUL, RNE, 16'h0000, 4'h0);
        add_entry(16'h3c00, 16'h0000, 16'h4000, OP_ADD, RNE, 16'h4200, 4'h0); // 1+2, y unused
        add_entry(16'h4000, 16'h4000, 16'h3c00, OP_NP,  RNE, 16'hc200, 4'h0); // -4+1
        add_entry(16'h4000, 16'h4000, 16'h3c00, OP_NZ,  RNE, 16'h4200, 4'h0); // 4-1
        add_entry(16'h4000, 16'h4000, 16'h3c00, OP_NPZ, RNE, 16'hc500, 4'h0); // -4-1
        add_entry(16'h4000, 16'h3c00, 16'h4000, OP_NZ,  RZ,  16'h0000, 4'h0); // 2-2
        add_entry(16'h4000, 16'h3c00, 16'h4000, OP_NZ,  RNE, 16'h0000, 4'h0);
        add_entry(16'h4000, 16'h3c00, 16'h4000, OP_NZ,  RDN, 16'h8000, 4'h0);
        add_entry(16'h4000, 16'h3c00, 16'h4000, OP_NZ,  RUP, 16'h0000, 4'h0);
        add_entry(16'h0001, 16'h3c00, 16'h3c00, OP_FMA, RNE, 16'h3c00, 4'h0); // subnormal = 0
        add_entry(16'h7bff, 16'h4000, 16'h0000, OP_FMA, RZ,  16'h7bff, 4'h5); // overflow
        add_entry(16'h7bff, 16'h4000, 16'h0000, OP_FMA, RNE, 16'h7c00, 4'h5);
        add_entry(16'h7bff, 16'h4000, 16'h0000, OP_FMA, RDN, 16'h7bff, 4'h5);
        add_entry(16'h7bff, 16'h4000, 16'h0000, OP_FMA, RUP, 16'h7c00, 4'h5);
        add_entry(16'hfbff, 16'h4000, 16'h0000, OP_FMA, RDN, 16'hfc00, 4'h5);
        add_entry(16'hfbff, 16'h4000, 16'h0000, OP_FMA, RUP, 16'hfbff, 4'h5);
        add_entry(16'h0400, 16'h3800, 16'h0000, OP_FMA, RNE, 16'h0000, 4'h3); // 2^-15 flush
        add_entry(16'h8400, 16'h3800, 16'h0000, OP_FMA, RNE, 16'h8000, 4'h3);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        assert (!out_valid) else abort_run("out_valid high right after reset");

        fork
            feed_inputs();
            collect_outputs();
        join

        // nothing extra may follow the last entry
        out_ready = 1'b1;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            #1;
            assert (!out_valid) else abort_run("extra result after the last entry");
        end

        if (n_checked == vx_q.size()) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "not every entry was checked");
        end
    end

endmodule

// File: source/fma16_unit.sv
module fma16_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [15:0] x,
    input  logic [15:0] y,
    input  logic [15:0] z,
    input  logic        mul,
    input  logic        add,
    input  logic        negp,
    input  logic        negz,
    input  logic [1:0]  round_mode,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [15:0] result,
    output logic [3:0]  flags
);

    // producer side of the record
    logic                         p_valid;
    logic                         p_ready;
    logic                         p_sign;
    logic [6:0]                   p_exp;
    logic [2*fp16_pkg::MAN_W+1:0] p_mant;
    logic                         z_sign;
    logic [fp16_pkg::EXP_W-1:0]   z_exp;
    logic [fp16_pkg::MAN_W:0]     z_mant;
    logic                         spec_hit;
    logic [15:0]                  spec_result;
    logic                         spec_nv;
    logic [1:0]                   rnd;
    logic [fma_op_pkg::PROD_W-1:0] p_rec;

    // FIFO head, unpacked for the consumer
    logic                         q_valid;
    logic                         q_ready;
    logic                         q_sign;
    logic [6:0]                   q_exp;
    logic [2*fp16_pkg::MAN_W+1:0] q_mant;
    logic                         q_z_sign;
    logic [fp16_pkg::EXP_W-1:0]   q_z_exp;
    logic [fp16_pkg::MAN_W:0]     q_z_mant;
    logic                         q_spec_hit;
    logic [15:0]                  q_spec_result;
    logic                         q_spec_nv;
    logic [1:0]                   q_rnd;
    logic [fma_op_pkg::PROD_W-1:0] q_rec;

    fma16_product_stage u_prod (
        .clk, .rst_n, .in_valid, .in_ready, .x, .y, .z,
        .mul, .add, .negp, .negz, .round_mode,
        .p_valid, .p_ready, .p_sign, .p_exp, .p_mant,
        .z_sign, .z_exp, .z_mant, .spec_hit, .spec_result, .spec_nv, .rnd
    );

    // same field order on both sides of the buffer
    assign p_rec = {p_sign, p_exp, p_mant, z_sign, z_exp, z_mant,
                    spec_hit, spec_result, spec_nv, rnd};
    assign {q_sign, q_exp, q_mant, q_z_sign, q_z_exp, q_z_mant,
            q_spec_hit, q_spec_result, q_spec_nv, q_rnd} = q_rec;

    fma16_fifo #(.WIDTH(fma_op_pkg::PROD_W)) u_fifo (
        .clk, .rst_n,
        .in_valid(p_valid), .in_ready(p_ready), .in_data(p_rec),
        .out_valid(q_valid), .out_ready(q_ready), .out_data(q_rec)
    );

    fma16_sum_round u_sum (
        .clk, .rst_n, .in_valid(q_valid), .in_ready(q_ready),
        .p_sign(q_sign), .p_exp(q_exp), .p_mant(q_mant),
        .z_sign(q_z_sign), .z_exp(q_z_exp), .z_mant(q_z_mant),
        .spec_hit(q_spec_hit), .spec_result(q_spec_result), .spec_nv(q_spec_nv),
        .rnd(q_rnd), .out_valid, .out_ready, .result, .flags
    );

endmodule

// File: source/fma16_sum_round.sv
module fma16_sum_round (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic                         p_sign,
    input  logic [6:0]                   p_exp,
    input  logic [2*fp16_pkg::MAN_W+1:0] p_mant,
    input  logic                         z_sign,
    input  logic [fp16_pkg::EXP_W-1:0]   z_exp,
    input  logic [fp16_pkg::MAN_W:0]     z_mant,
    input  logic                         spec_hit,
    input  logic [15:0]                  spec_result,
    input  logic                         spec_nv,
    input  logic [1:0]                   rnd,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [15:0]                  result,
    output logic [3:0]                   flags
);

    ////////////////////////////////////////////////////////////////////////////
    // 40 bit field, bit 0 sticky, product at [24:3], bit 23 weighs 2^(e_base)
    // addend starts at [38:28], 15 places above the product, and moves right

    logic              sub;              // effective subtraction
    logic              prod_zero;
    logic [8:0]        amt_raw;          // two's complement shift before clamp
    logic              clamp;
    logic [6:0]        amt;
    logic [8:0]        e_base;           // biased exponent of field bit 23
    logic [39:0]       p_field;
    logic [39:0]       a_top;
    logic [39:0]       a_shift;
    logic [39:0]       a_low;            // bits pushed past the field
    logic [39:0]       a_field;
    logic [40:0]       diff;             // top bit is the borrow
    logic [39:0]       mag;
    logic              r_sign;
    logic [5:0]        lz;
    logic [39:0]       norm;
    logic              g, s;             // guard and sticky
    logic              inc;
    logic [11:0]       rounded;          // carry, hidden bit, fraction
    logic [8:0]        res_exp;
    logic signed [8:0] fin_exp;
    logic              to_inf;
    logic [15:0]       res_c;
    logic [3:0]        flg_c;

    assign sub       = p_sign ^ z_sign;
    assign prod_zero = (p_mant == '0);
    assign amt_raw   = 9'd15 + {{2{p_exp[6]}}, p_exp} - {4'd0, z_exp};
    assign clamp     = prod_zero | amt_raw[8];   // addend on top, product only sticky
    assign amt       = clamp ? 7'd0 : amt_raw[6:0];
    assign e_base    = clamp ? {4'd0, z_exp} - 9'd15 : {{2{p_exp[6]}}, p_exp};

    assign p_field            = {15'd0, p_mant, 3'd0};
    assign a_top              = {1'b0, z_mant, 28'd0};
    assign {a_shift, a_low}   = {a_top, 40'd0} >> amt;
    assign a_field            = {a_shift[39:1], a_shift[0] | (|a_low)};
    assign diff               = {1'b0, p_field} - {1'b0, a_field};

    always_comb begin
        if (!sub) begin
            mag    = p_field + a_field;
            r_sign = p_sign;
        end else if (!diff[40]) begin
            mag    = diff[39:0];
            r_sign = p_sign;
        end else begin
            mag    = a_field - p_field;   // addend larger, its sign wins
            r_sign = z_sign;
        end
    end

    // leading zero count, highest set bit wins
    always_comb begin
        lz = 6'd0;
        for (int i = 0; i < 40; i++) begin
            if (mag[i]) lz = 6'(39 - i);
        end
    end

    assign norm    = mag << lz;
    assign res_exp = e_base + 9'd16 - {3'd0, lz};
    assign g       = norm[28];
    assign s       = |norm[27:0];

    ////////////////////////////////////////////////////////////////////////////
    // rounding

    always_comb begin
        case (rnd)
            fma_op_pkg::RND_RZ:  inc = 1'b0;
            fma_op_pkg::RND_RNE: inc = g & (s | norm[29]);   // ties go to even
            fma_op_pkg::RND_RDN: inc = r_sign & (g | s);
            fma_op_pkg::RND_RUP: inc = ~r_sign & (g | s);
        endcase
    end

    assign rounded = {1'b0, norm[39:29]} + 12'(inc);
    assign fin_exp = res_exp + {8'd0, rounded[11]};   // mantissa carry bumps exponent
    assign to_inf  = (rnd == fma_op_pkg::RND_RNE) |
                     ((rnd == fma_op_pkg::RND_RUP) & ~r_sign) |
                     ((rnd == fma_op_pkg::RND_RDN) & r_sign);

    always_comb begin
        res_c = {r_sign, fin_exp[fp16_pkg::EXP_W-1:0], rounded[fp16_pkg::MAN_W-1:0]};
        flg_c = '0;
        flg_c[fma_op_pkg::FLAG_NX] = g | s;
        if (spec_hit) begin
            res_c = spec_result;                       // decided by the producer
            flg_c = '0;
            flg_c[fma_op_pkg::FLAG_NV] = spec_nv;
        end else if (mag == '0) begin
            // exact zero, -0 only for rdn cancel or two negative zeros
            res_c = {sub ? (rnd == fma_op_pkg::RND_RDN) : p_sign, 15'd0};
        end else if (fin_exp >= fp16_pkg::EXP_MAX) begin
            res_c = to_inf ? {r_sign, fp16_pkg::POS_INF[14:0]}
                           : {r_sign, fp16_pkg::MAX_FINITE[14:0]};
            flg_c[fma_op_pkg::FLAG_OF] = 1'b1;
            flg_c[fma_op_pkg::FLAG_NX] = 1'b1;
        end else if (fin_exp <= 0) begin
            res_c = {r_sign, 15'd0};                   // flush to signed zero
            flg_c[fma_op_pkg::FLAG_UF] = 1'b1;
            flg_c[fma_op_pkg::FLAG_NX] = 1'b1;
        end
    end

    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            result <= res_c;
            flags  <= flg_c;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(result) && $stable(flags));

endmodule

// File: source/fma16_fifo.sv
module fma16_fifo #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic [WIDTH-1:0]                          mem [fma_op_pkg::FIFO_DEPTH];
    logic [$clog2(fma_op_pkg::FIFO_DEPTH)-1:0] rd_ptr;   // wraps, depth is a power of two
    logic [$clog2(fma_op_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(fma_op_pkg::FIFO_DEPTH):0]   count;    // 0 .. depth
    logic                                      wr;
    logic                                      rd;

    assign wr = in_valid & in_ready;
    assign rd = out_valid & out_ready;

    // full still takes a write when the head leaves on the same edge
    assign in_ready  = (count < fma_op_pkg::FIFO_DEPTH) | out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) wr_ptr <= wr_ptr + 1'b1;
            if (rd) rd_ptr <= rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or pass-through
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr) mem[wr_ptr] <= in_data;
    end

    a_no_over: assert property (@(posedge clk) disable iff (!rst_n)
        count <= fma_op_pkg::FIFO_DEPTH);

    // empty means the pointers met, so the head is never read stale
    a_empty_ptrs: assert property (@(posedge clk) disable iff (!rst_n)
        count == '0 |-> rd_ptr == wr_ptr);

endmodule

// File: source/fma16_product_stage.sv
module fma16_product_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [15:0]                  x,
    input  logic [15:0]                  y,
    input  logic [15:0]                  z,
    input  logic                         mul,          // low takes y as 1.0
    input  logic                         add,          // low takes z as -0
    input  logic                         negp,
    input  logic                         negz,
    input  logic [1:0]                   round_mode,
    output logic                         p_valid,
    input  logic                         p_ready,
    output logic                         p_sign,
    output logic [6:0]                   p_exp,        // biased, may leave range
    output logic [2*fp16_pkg::MAN_W+1:0] p_mant,       // exact, point below bit 20
    output logic                         z_sign,
    output logic [fp16_pkg::EXP_W-1:0]   z_exp,
    output logic [fp16_pkg::MAN_W:0]     z_mant,
    output logic                         spec_hit,
    output logic [15:0]                  spec_result,
    output logic                         spec_nv,
    output logic [1:0]                   rnd
);

    logic [15:0]                y_op;                // after opcode substitution
    logic [15:0]                z_op;
    logic                       xs, ys, zs;
    logic [fp16_pkg::EXP_W-1:0] xe, ye, ze;
    logic [fp16_pkg::MAN_W:0]   xm, ym, zm;
    logic                       x_zero, y_zero;
    logic                       x_inf, y_inf, z_inf;
    logic                       x_qnan, y_qnan, z_qnan;
    logic                       x_snan, y_snan, z_snan;
    logic                       ps;                  // product sign after negp
    logic                       any_nan, any_snan;
    logic                       zero_inf;            // 0 * inf
    logic                       prod_inf;
    logic                       inf_diff;            // inf - inf
    logic                       bad_op;
    logic [15:0]                spec_c;

    assign y_op = mul ? y : fp16_pkg::ONE;
    assign z_op = add ? {z[15] ^ negz, z[14:0]} : 16'h8000;   // -0 keeps a zero product's sign

    fma16_classify u_cls_x (.operand(x), .sign(xs), .exp(xe), .mant(xm), .is_zero(x_zero),
                            .is_inf(x_inf), .is_qnan(x_qnan), .is_snan(x_snan));
    fma16_classify u_cls_y (.operand(y_op), .sign(ys), .exp(ye), .mant(ym), .is_zero(y_zero),
                            .is_inf(y_inf), .is_qnan(y_qnan), .is_snan(y_snan));
    fma16_classify u_cls_z (.operand(z_op), .sign(zs), .exp(ze), .mant(zm), .is_zero(),
                            .is_inf(z_inf), .is_qnan(z_qnan), .is_snan(z_snan));

    ////////////////////////////////////////////////////////////////////////////
    // special cases, decided here so the sum stage only bypasses

    assign ps       = xs ^ ys ^ negp;
    assign any_nan  = x_qnan | x_snan | y_qnan | y_snan | z_qnan | z_snan;
    assign any_snan = x_snan | y_snan | z_snan;
    assign zero_inf = (x_zero & y_inf) | (y_zero & x_inf);
    assign prod_inf = x_inf | y_inf;
    assign inf_diff = prod_inf & z_inf & (ps ^ zs);
    assign bad_op   = any_nan | zero_inf | inf_diff;

    assign spec_c = bad_op   ? fp16_pkg::QNAN :
                    prod_inf ? {ps, fp16_pkg::POS_INF[14:0]} :
                               {zs, fp16_pkg::POS_INF[14:0]};   // finite product, inf addend

    assign in_ready = ~p_valid | p_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p_valid <= 1'b0;
        end else if (in_ready) begin
            p_valid <= in_valid;
        end
    end

    // record payload, loaded on accept only
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            p_sign      <= ps;
            p_exp       <= 7'(xe) + 7'(ye) - 7'(fp16_pkg::BIAS);
            p_mant      <= 22'(xm) * 22'(ym);
            z_sign      <= zs;
            z_exp       <= ze;
            z_mant      <= zm;
            spec_hit    <= bad_op | prod_inf | z_inf;
            spec_result <= spec_c;
            spec_nv     <= any_snan | (~any_nan & (zero_inf | inf_diff));   // quiet nan wins
            rnd         <= round_mode;
        end
    end

    a_rec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        p_valid && !p_ready |=> p_valid && $stable({p_sign, p_exp, p_mant, z_sign, z_exp,
                                                    z_mant, spec_hit, spec_result, spec_nv, rnd}));

endmodule

// File: source/fma16_classify.sv
module fma16_classify (
    input  logic [15:0]                operand,
    output logic                       sign,
    output logic [fp16_pkg::EXP_W-1:0] exp,
    output logic [fp16_pkg::MAN_W:0]   mant,      // hidden bit on top
    output logic                       is_zero,
    output logic                       is_inf,
    output logic                       is_qnan,
    output logic                       is_snan
);

    logic [fp16_pkg::MAN_W-1:0] frac;       // stored fraction
    logic                       exp_ones;   // inf or nan exponent

    assign sign     = operand[15];
    assign exp      = operand[14 -: fp16_pkg::EXP_W];
    assign frac     = operand[fp16_pkg::MAN_W-1:0];
    assign exp_ones = (int'(exp) == fp16_pkg::EXP_MAX);

    // zero exponent is zero, subnormals flushed along with it
    assign is_zero = (exp == '0);
    assign mant    = is_zero ? '0 : {1'b1, frac};

    assign is_inf  = exp_ones & ~|frac;
    // top fraction bit tells quiet from signaling
    assign is_qnan = exp_ones & frac[fp16_pkg::MAN_W-1];
    assign is_snan = exp_ones & ~frac[fp16_pkg::MAN_W-1] & |frac;

endmodule

// File: source/fma_op_pkg.sv
package fma_op_pkg;

    // rounding mode codes
    localparam logic [1:0] RND_RZ  = 2'd0;   // toward zero
    localparam logic [1:0] RND_RNE = 2'd1;   // nearest, ties to even
    localparam logic [1:0] RND_RDN = 2'd2;   // toward -inf
    localparam logic [1:0] RND_RUP = 2'd3;   // toward +inf

    // bit positions in the 4 bit flag vector
    localparam int FLAG_NV = 3;   // invalid
    localparam int FLAG_OF = 2;   // overflow
    localparam int FLAG_UF = 1;   // underflow
    localparam int FLAG_NX = 0;   // inexact

    // bits in one packed product record
    localparam int PROD_W = 67;

    localparam int FIFO_DEPTH = 4;   // records held between the two stages

endpackage

// File: source/fp16_pkg.sv
package fp16_pkg;

    // field widths of one binary16 word
    localparam int EXP_W = 5;
    localparam int MAN_W = 10;   // stored fraction, hidden bit not counted

    localparam int BIAS    = 15;   // exponent bias
    localparam int EXP_MAX = 31;   // all ones exponent, inf or nan

    ////////////////////////////////////////////////////////////////////////////
    // fixed encodings

    localparam logic [15:0] QNAN       = 16'h7e00;   // canonical quiet nan
    localparam logic [15:0] POS_INF    = 16'h7c00;   // +inf, sign patched in
    localparam logic [15:0] MAX_FINITE = 16'h7bff;   // 65504
    localparam logic [15:0] ONE        = 16'h3c00;   // 1.0 for add-only ops

endpackage
